// File: common/rx_pkg.sv
/*
 * Receive path definitions
 * Word, slot and counter widths, training pattern, lock threshold
 * and the control state encoding shared by the deserializer blocks
 */

`default_nettype none

package rx_pkg;

    //**********************************************************************
    // Word geometry
    //**********************************************************************
    localparam int word_width = 4;                      // Deserialization factor

    typedef logic [word_width-1:0] word_t;              // One parallel word
    typedef logic [1:0]            slot_t;              // Bit position in word

    localparam slot_t slot_last = slot_t'(word_width - 1); // Last slot before wrap

    //**********************************************************************
    // Startup wait
    //**********************************************************************
    typedef logic [7:0] startup_t;                      // Post-reset wait count

    localparam startup_t startup_last = 8'd255;         // Saturation value

    //**********************************************************************
    // Lock detection
    //**********************************************************************
    // Every rotation of this word differs, so only one slip phase matches
    localparam word_t training_word = 4'b0011;

    typedef logic [2:0] match_t;                        // Consecutive matches

    localparam match_t lock_matches = 3'd4;             // Matches needed for lock

    //**********************************************************************
    // Control FSM
    //**********************************************************************
    typedef enum logic [1:0] {
        st_startup,                                     // Waiting out startup
        st_hunt,                                        // Slips allowed
        st_locked                                       // Link ready, sticky
    } rx_state_t;

endpackage

`default_nettype wire

// File: deser/deser_shift.sv
/*
 * Serial to parallel shifter
 * One bit per clock enters the word, first bit ends up in the MSB.
 * A slot counter marks word boundaries and a slip stretches one word.
 */

`default_nettype none

module deser_shift (
    input  logic          fabric_clk_div,
    input  logic          reset_buf_n,
    input  logic          data_i,               // Serial bit, one per clock
    input  logic          enable_n,             // Low lets data through
    input  logic          slip_pulse,           // Move boundary by one bit
    output rx_pkg::word_t word,                 // Most recent bits, MSB oldest
    output logic          word_strobe           // Word valid this cycle
);

    import rx_pkg::*;

    logic  bit_in;                              // Gated serial bit
    slot_t slot;                                // Position in current word
    word_t shift_q;                             // Shift register

    // Disabled input reads as zero
    assign bit_in = data_i & ~enable_n;

    assign word = shift_q;                      // Sampled only on strobe

    //**********************************************************************
    // Shift register
    //**********************************************************************
    always_ff @(posedge fabric_clk_div) begin
        shift_q <= {shift_q[word_width-2:0], bit_in};   // New bit at LSB
    end

    //**********************************************************************
    // Word boundary
    //**********************************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            slot        <= '0;                  // Boundary at first bit
            word_strobe <= 1'b0;
        end else begin
            if (!slip_pulse) begin
                slot <= slot + slot_t'(1);      // Wraps every word
            end
            // Held counter means no wrap, so this word takes an extra cycle
            word_strobe <= (slot == slot_last) && !slip_pulse;
        end
    end

endmodule

`default_nettype wire

// File: design/pattern_lock.sv
/*
 * Training pattern lock detector
 * Counts consecutive training words and raises a sticky lock level.
 * A slip or a broken run clears the count.
 */

`default_nettype none

module pattern_lock (
    input  logic          fabric_clk_div,
    input  logic          reset_buf_n,
    input  rx_pkg::word_t word,                 // Candidate word
    input  logic          word_strobe,          // Word valid
    input  logic          slip_pulse,           // Boundary moved
    output logic          locked                // Sticky until reset
);

    import rx_pkg::*;

    match_t match_cnt;                          // Consecutive matches
    logic   is_match;                           // Strobed training word

    assign is_match = word_strobe && (word == training_word);

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            match_cnt <= '0;
            locked    <= 1'b0;
        end else begin
            if (slip_pulse) begin
                match_cnt <= '0;                // New phase, start over
            end else if (word_strobe) begin
                if (!is_match) begin
                    match_cnt <= '0;            // Run broken
                end else if (match_cnt != lock_matches) begin
                    match_cnt <= match_cnt + match_t'(1);
                end
            end

            // Lock in the cycle after the final matching strobe
            if (is_match && !slip_pulse &&
                (match_cnt == lock_matches - match_t'(1))) begin
                locked <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rx_startup_timer.sv
/*
 * Post-reset startup timer
 * Saturating counter, flags the end of the wait after reset release
 */

`default_nettype none

module rx_startup_timer (
    input  logic fabric_clk_div,
    input  logic reset_buf_n,
    output logic startup_done                   // Wait over, stays high
);

    import rx_pkg::*;

    startup_t wait_cnt;                         // Cycles since reset release

    //**********************************************************************
    // Count up and hold at the top value
    //**********************************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt     <= '0;
            startup_done <= 1'b0;
        end else if (wait_cnt != startup_last) begin
            wait_cnt     <= wait_cnt + startup_t'(1);
            // Goes high together with the counter reaching the top
            startup_done <= (wait_cnt == startup_last - startup_t'(1));
        end
    end

endmodule

`default_nettype wire

// File: design/rx_control.sv
/*
 * Receive control FSM
 * Sequences startup, hunt and locked, turns bitslip falling edges into
 * single-cycle slips while hunting and drives the ready level
 */

`default_nettype none

module rx_control (
    input  logic fabric_clk_div,
    input  logic reset_buf_n,
    input  logic startup_done,                  // Startup wait over
    input  logic locked,                        // Training pattern seen
    input  logic bitslip_n,                     // Operator slip, active low
    output logic slip_pulse,                    // One cycle per request
    output logic ready                          // Link up
);

    import rx_pkg::*;

    rx_state_t state;                           // Current state
    rx_state_t state_next;                      // Next state
    logic      bitslip_q;                       // Synchronizer stage
    logic      bitslip_q2;                      // Previous sample
    logic      slip_fall;                       // High to low seen

    //**********************************************************************
    // Bitslip edge detect
    //**********************************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bitslip_q  <= 1'b1;                 // Idle level is high
            bitslip_q2 <= 1'b1;
        end else begin
            bitslip_q  <= bitslip_n;
            bitslip_q2 <= bitslip_q;
        end
    end

    assign slip_fall = bitslip_q2 & ~bitslip_q;

    //**********************************************************************
    // State machine
    //**********************************************************************
    always_comb begin
        state_next = state;
        case (state)
            st_startup: begin
                if (startup_done) begin
                    state_next = st_hunt;
                end
            end
            st_hunt: begin
                if (locked) begin
                    state_next = st_locked;
                end
            end
            st_locked: begin
                state_next = st_locked;         // Only reset leaves
            end
            default: begin
                state_next = st_startup;
            end
        endcase
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state      <= st_startup;
            slip_pulse <= 1'b0;
            ready      <= 1'b0;
        end else begin
            state      <= state_next;
            // Requests outside hunt are dropped
            slip_pulse <= slip_fall && (state == st_hunt);
            ready      <= (state_next == st_locked);    // Tracks the state register
        end
    end

endmodule

`default_nettype wire

// File: design/word_capture.sv
/*
 * Output word register
 * Loads strobed words once the link is ready, holds otherwise
 */

`default_nettype none

module word_capture (
    input  logic          fabric_clk_div,
    input  logic          reset_buf_n,
    input  rx_pkg::word_t word,                 // Deserialized word
    input  logic          word_strobe,          // Word valid
    input  logic          ready,                // Link up
    output rx_pkg::word_t data_o                // Registered output word
);

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;                       // Pins read zero in reset
        end else if (word_strobe && ready) begin
            data_o <= word;
        end
    end

endmodule

`default_nettype wire

// File: design/serial_rx_top.sv
/*
 * Serial receive path top level
 * Deserializer, lock detector, startup timer, control FSM and
 * output register between the pins
 */

`default_nettype none

module serial_rx_top (
    input  logic          fabric_clk_div,       // One serial bit per cycle
    input  logic          reset_buf_n,          // Async, active low
    input  logic          enable_n,             // Input enable, active low
    input  logic          data_i,               // Serial data
    input  logic          bitslip_n,            // Slip request, active low
    output rx_pkg::word_t data_o,               // Received word
    output logic          ready                 // Link up
);

    import rx_pkg::*;

    word_t word;                                // Deserializer output
    logic  word_strobe;                         // Word boundary
    logic  slip_pulse;                          // Qualified slip
    logic  locked;                              // Pattern lock
    logic  startup_done;                        // Startup wait over

    deser_shift u_deser_shift (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .enable_n       (enable_n),
        .slip_pulse     (slip_pulse),
        .word           (word),
        .word_strobe    (word_strobe)
    );

    pattern_lock u_pattern_lock (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .word_strobe    (word_strobe),
        .slip_pulse     (slip_pulse),
        .locked         (locked)
    );

    rx_startup_timer u_rx_startup_timer (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .startup_done   (startup_done)
    );

    rx_control u_rx_control (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .startup_done   (startup_done),
        .locked         (locked),
        .bitslip_n      (bitslip_n),
        .slip_pulse     (slip_pulse),
        .ready          (ready)
    );

    word_capture u_word_capture (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .word_strobe    (word_strobe),
        .ready          (ready),
        .data_o         (data_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock generator
 * Free-running clock, one serial bit per period
 */

`default_nettype none

module tb_clock_gen #(
    parameter int period = 40                   // Clock period in time units
) (
    output logic fabric_clk_div
);

    initial begin
        fabric_clk_div = 1'b0;                  // Starts low, first rise at half period
        forever begin
            #(period / 2) fabric_clk_div = ~fabric_clk_div;
        end
    end

endmodule

`default_nettype wire

// File: tests/serial_rx_tb.sv
/*
 * Serial receive path testbench
 * Serializes training and random words into the DUT, slips the word
 * boundary into place and checks ready and data_o against its own model
 */

`default_nettype none

module serial_rx_tb;

    import rx_pkg::*;

    localparam int clk_period    = 40;
    localparam int startup_words = (int'(startup_last) + 1) / word_width; // Words in startup
    localparam int words_total   = 240;         // All phases, rounded up
    localparam int watchdog_time =
        (words_total * word_width + int'(startup_last) + 200) * clk_period;

    logic   fabric_clk_div;
    logic   reset_buf_n;
    logic   enable_n;
    logic   data_i;
    logic   bitslip_n;
    word_t  data_o;
    logic   ready;

    integer seed;                               // $random state
    int     value_errors;                       // Wrong values seen
    int     other_errors;                       // Missing or late events
    int     bit_pos;                            // Index of next bit since release
    int     since_rel;                          // Negedges since reset release
    int     slips_needed;                       // Predicted from training phase
    logic   armed;                              // Monitor active
    logic   track;                              // data_o compared with sent words
    logic   hold_low;                           // ready must stay low
    word_t  last_pushed;                        // Newest expected data_o value
    word_t  prev_data;                          // data_o at previous negedge
    word_t  sent_q[$];                          // Expected data_o changes

    tb_clock_gen #(.period(clk_period)) u_clock_gen (
        .fabric_clk_div (fabric_clk_div)
    );

    serial_rx_top UUT (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_n      (bitslip_n),
        .data_o         (data_o),
        .ready          (ready)
    );

    //**********************************************************************
    // Helpers
    //**********************************************************************
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h",
                     $time, name, actual, expected);
            value_errors++;
        end
    endtask

    // One serial bit, sampled by the DUT on the next rising edge
    task automatic drive_bit(input logic b, input logic dis);
        @(posedge fabric_clk_div);
        data_i   <= b;
        enable_n <= dis;
        bit_pos++;
    endtask

    // MSB first, optional bitslip pulse on the first bit
    task automatic send_word(input word_t w, input logic dis, input logic slip);
        word_t eff;
        int    i;
        for (i = word_width - 1; i >= 0; i--) begin
            drive_bit(w[i], dis);
            if (slip && i == word_width - 1) begin
                bitslip_n <= 1'b0;              // Falling edge is the request
            end else if (i == 1) begin
                bitslip_n <= 1'b1;
            end
        end
        eff = dis ? word_t'(0) : w;             // Disabled input reads zero
        if (track && eff != last_pushed) begin
            sent_q.push_back(eff);              // Only changes are visible
            last_pushed = eff;
        end
    endtask

    task automatic pad_to_phase(input int phase);
        while ((bit_pos % word_width) != phase) begin
            drive_bit(1'b0, 1'b0);
        end
    endtask

    task automatic reset_dut();
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b0;
        data_i      <= 1'b0;
        enable_n    <= 1'b0;
        bitslip_n   <= 1'b1;
        #1;
        compare_value("ready", ready, 0);       // Async clear
        compare_value("data_o", data_o, 0);
        repeat (2) @(posedge fabric_clk_div);
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b1;
        bit_pos = 1;                            // Bit 0 is the one driven now
    endtask

    // Training words until ready is seen at a negedge
    task automatic wait_ready(input int max_words);
        int n;
        n = 0;
        do begin
            send_word(training_word, 1'b0, 1'b0);
            @(negedge fabric_clk_div);
            n++;
        end while (!ready && n < max_words);
        assert (ready) else begin
            $display("%0t: ready did not rise within %0d words", $time, max_words);
            other_errors++;
        end
    endtask

    // Filler equal to the last value lets the last word arrive
    task automatic finish_tracking();
        send_word(last_pushed, 1'b0, 1'b0);
        assert (sent_q.size() == 0) else begin
            $display("%0t: %0d sent words never reached data_o", $time, sent_q.size());
            other_errors++;
        end
        track = 1'b0;
        sent_q.delete();
    endtask

    //**********************************************************************
    // Output monitor
    //**********************************************************************
    always @(negedge fabric_clk_div) begin
        if (armed) begin
            if (!reset_buf_n) begin
                since_rel = 0;
                compare_value("ready", ready, 0);
                compare_value("data_o", data_o, 0);
            end else begin
                since_rel++;
                if (since_rel <= int'(startup_last) + 1 || hold_low) begin
                    compare_value("ready", ready, 0);   // Startup or misaligned
                    compare_value("data_o", data_o, 0); // Nothing loaded before ready
                end
                if (track && data_o !== prev_data) begin
                    if (sent_q.size() == 0) begin
                        $display("%0t: data_o changed to %0h with no word pending",
                                 $time, data_o);
                        other_errors++;
                    end else begin
                        compare_value("data_o", data_o, sent_q.pop_front());
                    end
                end
            end
        end
        prev_data = data_o;
    end

    //**********************************************************************
    // Watchdog
    //**********************************************************************
    initial begin
        #(watchdog_time);
        $display("%0t: watchdog expired before the test sequence completed", $time);
        $display("Errors: value %0d, other %0d", value_errors, other_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //**********************************************************************
    // Test sequence
    //**********************************************************************
    initial begin
        int k;
        int offset;
        reset_buf_n  = 1'b0;
        enable_n     = 1'b0;
        data_i       = 1'b0;
        bitslip_n    = 1'b1;
        seed         = 94198;
        value_errors = 0;
        other_errors = 0;
        bit_pos      = 0;
        since_rel    = 0;
        armed        = 1'b0;
        track        = 1'b0;
        hold_low     = 1'b0;
        last_pushed  = '0;
        prev_data    = '0;
        @(posedge fabric_clk_div);
        armed = 1'b1;                           // Flops cleared by now

        // Aligned training from release, lock only after startup
        reset_dut();
        pad_to_phase(0);
        wait_ready(startup_words + 6);
        repeat (2) send_word(training_word, 1'b0, 1'b0);
        last_pushed = training_word;            // data_o holds training word
        track       = 1'b1;

        repeat (40) send_word(word_t'($random(seed)), 1'b0, 1'b0);

        // Gated input, then normal data again
        send_word(training_word, 1'b0, 1'b0);
        repeat (3) send_word(word_t'($random(seed)), 1'b1, 1'b0);
        repeat (8) send_word(word_t'($random(seed)), 1'b0, 1'b0);

        // Slip requests while locked
        for (k = 0; k < 12; k++) begin
            send_word(word_t'($random(seed)), 1'b0, (k % 2) == 0);
        end
        send_word(training_word, 1'b0, 1'b0);   // Nonzero before reset
        finish_tracking();

        // Mid-run reset, then training off by 1 to 3 bits
        reset_dut();
        hold_low = 1'b1;
        offset   = 1 + ($unsigned($random(seed)) % 3);
        pad_to_phase(offset);
        slips_needed = bit_pos % word_width;    // Training start vs boundary
        $display("Training phase %0d, %0d slips needed", offset, slips_needed);
        repeat (startup_words + 6) send_word(training_word, 1'b0, 1'b0);
        hold_low = 1'b0;
        repeat (slips_needed) begin
            send_word(training_word, 1'b0, 1'b1);
            send_word(training_word, 1'b0, 1'b0);   // 8 cycles between requests
        end
        wait_ready(6);
        repeat (2) send_word(training_word, 1'b0, 1'b0);
        last_pushed = training_word;
        track       = 1'b1;
        repeat (8) send_word(word_t'($random(seed)), 1'b0, 1'b0);
        finish_tracking();

        $display("Errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/rx_pkg.sv
deser/deser_shift.sv
design/pattern_lock.sv
design/rx_startup_timer.sv
design/rx_control.sv
design/word_capture.sv
design/serial_rx_top.sv
tests/tb_clock_gen.sv
tests/serial_rx_tb.sv
